//--- all.f
src/sdmacDataPkg.sv
src/sdmacCtrlPkg.sv
src/cpuWriteLatch.sv
src/wordFifo.sv
src/scsiSerializer.sv
src/scsiPacker.sv
src/cpuReadPort.sv
src/sdmacDatapath.sv
testbench/sdmacDatapathTb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module sdmacDatapathTb \
    -f all.f -o simv > sim.log 2>&1 \
    && ./obj_dir/simv >> sim.log 2>&1 \
    || echo "tests failed" >> sim.log
cat sim.log
grep -q "tests failed" sim.log && echo "FAIL" && exit 1 || echo "PASS"

//--- src/cpuReadPort.sv
// Holds one packed word for the CPU; dataOutEnable is combinational from cpuRdReq and dmaDir
`default_nettype none
`timescale 1ns/1ps

module cpuReadPort (
    input  wire logic                 CLK,
    input  wire logic                 reset,
    input  wire sdmacCtrlPkg::dmaDirT dmaDir,
    input  wire logic                 inReq,
    output logic                      inAck,
    input  wire sdmacDataPkg::inWordT inWord,
    input  wire logic                 cpuRdReq,
    output logic                      cpuRdAck,
    output sdmacDataPkg::inWordT      cpuRdWord,
    output logic                      dataOutEnable
);

    // Present holds a word for the CPU and settle closes the buffer side
    typedef enum logic [1:0] {idle, present, settle} stateT;

    stateT state;

    // Bus drivers turn on for a CPU read while data flows toward the CPU
    assign dataOutEnable = cpuRdReq && (dmaDir == sdmacCtrlPkg::toCpu);

    always_ff @(posedge CLK) begin
        if (state == idle && inReq && !inAck) begin
            cpuRdWord <= inWord;
        end
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            state    <= idle;
            inAck    <= 1'b0;
            cpuRdAck <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (inReq && !inAck) begin
                        state <= present;
                    end
                end
                present: begin
                    // Word is valid from the ack until the CPU drops its request
                    if (cpuRdReq && !cpuRdAck && (dmaDir == sdmacCtrlPkg::toCpu)) begin
                        cpuRdAck <= 1'b1;
                    end else if (cpuRdAck && !cpuRdReq) begin
                        cpuRdAck <= 1'b0;
                        inAck    <= 1'b1;
                        state    <= settle;
                    end
                end
                default: begin
                    if (!inReq) begin
                        inAck <= 1'b0;
                        state <= idle;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/cpuWriteLatch.sv
// Takes one CPU word per four-phase handshake in toScsi only; dmaDir must not change mid-write
`default_nettype none
`timescale 1ns/1ps

module cpuWriteLatch (
    input  wire logic                 CLK,
    input  wire logic                 reset,
    input  wire sdmacCtrlPkg::dmaDirT dmaDir,
    input  wire logic                 cpuWrReq,
    input  wire sdmacDataPkg::outWordT cpuWrWord,
    output logic                      cpuWrAck,
    output logic                      outReq,
    input  wire logic                 outAck,
    output sdmacDataPkg::outWordT     outWord
);

    // Idle waits for the CPU, push runs the downstream handshake and
    // settle finishes the CPU side once the buffer has the word
    typedef enum logic [1:0] {idle, push, settle} stateT;

    stateT state;
    logic  take;

    // A write is only accepted in toScsi and with the downstream link at rest
    assign take = (state == idle) && cpuWrReq && !outAck &&
                  (dmaDir == sdmacCtrlPkg::toScsi);

    // The word and its lane enables are held until the buffer acks
    always_ff @(posedge CLK) begin
        if (take) begin
            outWord <= cpuWrWord;
        end
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            state    <= idle;
            cpuWrAck <= 1'b0;
            outReq   <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (take) begin
                        outReq <= 1'b1;
                        state  <= push;
                    end
                end
                push: begin
                    // The CPU sees its ack one cycle after the buffer took the word
                    if (outAck) begin
                        outReq   <= 1'b0;
                        cpuWrAck <= 1'b1;
                        state    <= settle;
                    end
                end
                default: begin
                    if (!cpuWrReq) begin
                        cpuWrAck <= 1'b0;
                        state    <= idle;
                    end
                end
            endcase
        end
    end

    // The CPU has to keep its request up until it sees the ack
    cpuAckNeedsReq: assert property (@(posedge CLK) disable iff (reset)
        $rose(cpuWrAck) |-> cpuWrReq);

endmodule

`default_nettype wire

//--- src/scsiPacker.sv
// Packs halves lower first in toCpu only; scsiEnd is a level that may rise only while scsiInReq is low
`default_nettype none
`timescale 1ns/1ps

module scsiPacker (
    input  wire logic                 CLK,
    input  wire logic                 reset,
    input  wire sdmacCtrlPkg::dmaDirT dmaDir,
    input  wire logic                 scsiInReq,
    input  wire sdmacDataPkg::halfT   scsiInData,
    input  wire logic                 scsiEnd,
    output logic                      scsiInAck,
    output logic                      outReq,
    input  wire logic                 outAck,
    output sdmacDataPkg::inWordT      outWord
);

    sdmacDataPkg::halfT lowHalf;
    logic               haveLow;
    logic               outBusy;
    logic               takeHalf;

    // A word is still on its way to the buffer until its ack has fallen
    assign outBusy = outReq || outAck;

    // A lower half is always welcome, but an upper half needs a free output
    assign takeHalf = scsiInReq && !scsiInAck && (dmaDir == sdmacCtrlPkg::toCpu) &&
                      (!haveLow || !outBusy);

    always_ff @(posedge CLK) begin
        if (reset) begin
            lowHalf   <= '0;
            haveLow   <= 1'b0;
            scsiInAck <= 1'b0;
            outReq    <= 1'b0;
        end else begin
            // SCSI input handshake
            if (takeHalf) begin
                scsiInAck <= 1'b1;
                if (!haveLow) begin
                    lowHalf <= scsiInData;
                    haveLow <= 1'b1;
                end else begin
                    // Second half completes the word
                    outWord.data      <= {scsiInData, lowHalf};
                    outWord.halfValid <= 2'b11;
                    outReq            <= 1'b1;
                    haveLow           <= 1'b0;
                end
            end else if (scsiEnd && haveLow && !outBusy) begin
                // End of transfer pushes the lone half with a zero upper half
                outWord.data      <= {{sdmacDataPkg::halfWidth{1'b0}}, lowHalf};
                outWord.halfValid <= 2'b01;
                outReq            <= 1'b1;
                haveLow           <= 1'b0;
            end else if (scsiInAck && !scsiInReq) begin
                scsiInAck <= 1'b0;
            end

            // Buffer side
            if (outReq && outAck) begin
                outReq <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/scsiSerializer.sv
// Sends enabled halves lower first and acks the buffer after the last; inWord must hold until then
`default_nettype none
`timescale 1ns/1ps

module scsiSerializer (
    input  wire logic                  CLK,
    input  wire logic                  reset,
    input  wire logic                  inReq,
    output logic                       inAck,
    input  wire sdmacDataPkg::outWordT inWord,
    output logic                       scsiOutReq,
    input  wire logic                  scsiOutAck,
    output sdmacDataPkg::halfT         scsiOutData
);

    // Load picks the next enabled half, send waits for the SCSI ack,
    // drain waits for it to fall and finish closes the buffer handshake
    typedef enum logic [2:0] {idle, load, send, drain, finish} stateT;

    stateT      state;
    logic [1:0] pending;

    always_ff @(posedge CLK) begin
        if (reset) begin
            state       <= idle;
            pending     <= 2'b00;
            inAck       <= 1'b0;
            scsiOutReq  <= 1'b0;
            scsiOutData <= '0;
        end else begin
            case (state)
                idle: begin
                    if (inReq && !inAck) begin
                        pending <= inWord.laneEnable;
                        state   <= load;
                    end
                end
                load: begin
                    // Lower lane goes first and a disabled lane is skipped
                    if (pending[0] && !scsiOutAck) begin
                        scsiOutData <= inWord.data[sdmacDataPkg::halfWidth-1:0];
                        scsiOutReq  <= 1'b1;
                        pending[0]  <= 1'b0;
                        state       <= send;
                    end else if (pending[1] && !scsiOutAck) begin
                        scsiOutData <= inWord.data[sdmacDataPkg::wordWidth-1:
                                                   sdmacDataPkg::halfWidth];
                        scsiOutReq  <= 1'b1;
                        pending[1]  <= 1'b0;
                        state       <= send;
                    end else if (pending == 2'b00) begin
                        // Nothing left, so the word is done, even one with no lanes
                        inAck <= 1'b1;
                        state <= finish;
                    end
                end
                send: begin
                    if (scsiOutAck) begin
                        scsiOutReq <= 1'b0;
                        state      <= drain;
                    end
                end
                drain: begin
                    if (!scsiOutAck) begin
                        state <= load;
                    end
                end
                default: begin
                    if (!inReq) begin
                        inAck <= 1'b0;
                        state <= idle;
                    end
                end
            endcase
        end
    end

    // The SCSI side must have dropped its ack before the next half is offered
    scsiReqAfterAckLow: assert property (@(posedge CLK) disable iff (reset)
        $rose(scsiOutReq) |-> !scsiOutAck);

endmodule

`default_nettype wire

//--- src/sdmacCtrlPkg.sv
// Control encodings; toCpu matches a high DMA direction bit and the depth must be at least 1
`default_nettype none

package sdmacCtrlPkg;

    // Transfer direction, which selects the active pipeline
    // toScsi carries CPU writes out and toCpu carries SCSI data in
    typedef enum logic {
        toScsi = 1'b0,
        toCpu  = 1'b1
    } dmaDirT;

    // Number of words held by each direction's buffer
    localparam int fifoDepth = 4;

endpackage

`default_nettype wire

//--- src/sdmacDataPkg.sv
// Widths and payload structs for both data paths; SCSI halves always travel lower half first
`default_nettype none

package sdmacDataPkg;

    // Width of the CPU/DMA bus
    localparam int wordWidth = 32;

    // Width of the SCSI data port
    localparam int halfWidth = 16;

    // One full CPU word and one SCSI half
    typedef logic [wordWidth-1:0] wordT;
    typedef logic [halfWidth-1:0] halfT;

    // Word on its way to SCSI
    // Bit 1 of laneEnable selects the upper half and bit 0 the lower half
    typedef struct packed {
        wordT       data;
        logic [1:0] laneEnable;
    } outWordT;

    // Word packed from SCSI halves
    // halfValid is 11 for a full word and 01 for a flushed lone half
    typedef struct packed {
        wordT       data;
        logic [1:0] halfValid;
    } inWordT;

endpackage

`default_nettype wire

//--- src/sdmacDatapath.sv
// Both data pipelines on one clock; dmaDir selects the path and the other one stays idle
`default_nettype none
`timescale 1ns/1ps

module sdmacDatapath (
    input  wire logic                  CLK,
    input  wire logic                  reset,
    input  wire sdmacCtrlPkg::dmaDirT  dmaDir,
    input  wire logic                  cpuWrReq,
    output logic                       cpuWrAck,
    input  wire sdmacDataPkg::outWordT cpuWrWord,
    input  wire logic                  cpuRdReq,
    output logic                       cpuRdAck,
    output sdmacDataPkg::inWordT       cpuRdWord,
    output logic                       dataOutEnable,
    output logic                       scsiOutReq,
    input  wire logic                  scsiOutAck,
    output sdmacDataPkg::halfT         scsiOutData,
    input  wire logic                  scsiInReq,
    output logic                       scsiInAck,
    input  wire sdmacDataPkg::halfT    scsiInData,
    input  wire logic                  scsiEnd
);

    // To-SCSI path links
    logic                  wrFifoReq;
    logic                  wrFifoAck;
    sdmacDataPkg::outWordT wrFifoWord;
    logic                  fifoSerReq;
    logic                  fifoSerAck;
    sdmacDataPkg::outWordT fifoSerWord;

    // From-SCSI path links
    logic                  packFifoReq;
    logic                  packFifoAck;
    sdmacDataPkg::inWordT  packFifoWord;
    logic                  fifoRdReq;
    logic                  fifoRdAck;
    sdmacDataPkg::inWordT  fifoRdWord;

    cpuWriteLatch wrLatch (
        .CLK(CLK), .reset(reset), .dmaDir(dmaDir),
        .cpuWrReq(cpuWrReq), .cpuWrWord(cpuWrWord), .cpuWrAck(cpuWrAck),
        .outReq(wrFifoReq), .outAck(wrFifoAck), .outWord(wrFifoWord)
    );

    wordFifo #(.payloadT(sdmacDataPkg::outWordT), .depth(sdmacCtrlPkg::fifoDepth)) outFifo (
        .CLK(CLK), .reset(reset),
        .inReq(wrFifoReq), .inAck(wrFifoAck), .inData(wrFifoWord),
        .outReq(fifoSerReq), .outAck(fifoSerAck), .outData(fifoSerWord)
    );

    scsiSerializer serializer (
        .CLK(CLK), .reset(reset),
        .inReq(fifoSerReq), .inAck(fifoSerAck), .inWord(fifoSerWord),
        .scsiOutReq(scsiOutReq), .scsiOutAck(scsiOutAck), .scsiOutData(scsiOutData)
    );

    scsiPacker packer (
        .CLK(CLK), .reset(reset), .dmaDir(dmaDir),
        .scsiInReq(scsiInReq), .scsiInData(scsiInData), .scsiEnd(scsiEnd),
        .scsiInAck(scsiInAck),
        .outReq(packFifoReq), .outAck(packFifoAck), .outWord(packFifoWord)
    );

    wordFifo #(.payloadT(sdmacDataPkg::inWordT), .depth(sdmacCtrlPkg::fifoDepth)) inFifo (
        .CLK(CLK), .reset(reset),
        .inReq(packFifoReq), .inAck(packFifoAck), .inData(packFifoWord),
        .outReq(fifoRdReq), .outAck(fifoRdAck), .outData(fifoRdWord)
    );

    cpuReadPort rdPort (
        .CLK(CLK), .reset(reset), .dmaDir(dmaDir),
        .inReq(fifoRdReq), .inAck(fifoRdAck), .inWord(fifoRdWord),
        .cpuRdReq(cpuRdReq), .cpuRdAck(cpuRdAck), .cpuRdWord(cpuRdWord),
        .dataOutEnable(dataOutEnable)
    );

endmodule

`default_nettype wire

//--- src/wordFifo.sv
// Circular buffer of depth entries with four-phase sides; outData is read straight from storage
`default_nettype none
`timescale 1ns/1ps

module wordFifo #(
    parameter type payloadT = sdmacDataPkg::outWordT,
    parameter int  depth    = sdmacCtrlPkg::fifoDepth
) (
    input  wire logic    CLK,
    input  wire logic    reset,
    input  wire logic    inReq,
    output logic         inAck,
    input  wire payloadT inData,
    output logic         outReq,
    input  wire logic    outAck,
    output payloadT      outData
);

    localparam int ptrW = (depth > 1) ? $clog2(depth) : 1;
    localparam int cntW = $clog2(depth + 1);

    payloadT         mem [depth];
    logic [ptrW-1:0] wrPtr;
    logic [ptrW-1:0] rdPtr;
    logic [cntW-1:0] count;
    logic            push;
    logic            pop;

    // Pointers wrap by hand so that any depth works
    function automatic logic [ptrW-1:0] nextPtr(input logic [ptrW-1:0] ptr);
        return (ptr == ptrW'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // A new request is taken only when there is room, which is the back-pressure
    assign push = inReq && !inAck && (count != cntW'(depth));
    assign pop = outReq && outAck;

    // The read pointer only moves on a pop, so the word holds while outReq is up
    assign outData = mem[rdPtr];

    always_ff @(posedge CLK) begin
        if (push) begin
            mem[wrPtr] <= inData;
        end
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            wrPtr  <= '0;
            rdPtr  <= '0;
            count  <= '0;
            inAck  <= 1'b0;
            outReq <= 1'b0;
        end else begin
            if (push) begin
                wrPtr <= nextPtr(wrPtr);
                inAck <= 1'b1;
            end else if (inAck && !inReq) begin
                inAck <= 1'b0;
            end
            // Output request rises only once the previous handshake has fully ended
            if (pop) begin
                rdPtr  <= nextPtr(rdPtr);
                outReq <= 1'b0;
            end else if (!outReq && !outAck && (count != '0)) begin
                outReq <= 1'b1;
            end
            count <= count + cntW'(push) - cntW'(pop);
        end
    end

    // A write must never land on a word that has not been read yet
    noWriteWhenFull: assert property (@(posedge CLK) disable iff (reset)
        push |-> ((wrPtr != rdPtr) || (count == '0)));

    // The reader may sample at any point of its handshake
    outDataStable: assert property (@(posedge CLK) disable iff (reset)
        ($past(outReq) && outReq) |-> $stable(outData));

endmodule

`default_nettype wire

//--- testbench/sdmacDatapathTb.sv
// Single 10 ns clock; SCSI output acks rise after 0 to 3 cycles and fall 1 to 3 cycles late, fixed seed
`default_nettype none
`timescale 1ns/1ps

module sdmacDatapathTb;

    localparam int runWords = 8;
    localparam int backWords = sdmacCtrlPkg::fifoDepth + 3;
    // Every word costs at most three handshakes in either direction
    localparam int handshakes = 3 * (4 * runWords + backWords);
    localparam int cycleLimit = 20 * handshakes + 200;

    logic                  CLK;
    logic                  reset;
    sdmacCtrlPkg::dmaDirT  dmaDir;
    logic                  cpuWrReq;
    logic                  cpuWrAck;
    sdmacDataPkg::outWordT cpuWrWord;
    logic                  cpuRdReq;
    logic                  cpuRdAck;
    sdmacDataPkg::inWordT  cpuRdWord;
    logic                  dataOutEnable;
    logic                  scsiOutReq;
    logic                  scsiOutAck;
    sdmacDataPkg::halfT    scsiOutData;
    logic                  scsiInReq;
    logic                  scsiInAck;
    sdmacDataPkg::halfT    scsiInData;
    logic                  scsiEnd;

    // Reference queues, filled in the order the rules say data must come out
    sdmacDataPkg::halfT    expHalves[$];
    sdmacDataPkg::inWordT  expWords[$];

    // Values captured by the responders and handed to the assertions for one cycle
    sdmacDataPkg::halfT    gotHalf;
    sdmacDataPkg::halfT    expHalf;
    logic                  halfStrobe;
    logic                  halfExpected;
    sdmacDataPkg::inWordT  gotWord;
    sdmacDataPkg::inWordT  expWord;
    logic                  wordStrobe;
    logic                  wordExpected;
    logic                  holdOff;
    logic                  stallStrobe;
    logic [12:0]           linkBits;

    int wrAcked = 0;
    int writesDone = 0;
    int halvesSeen = 0;
    int wordsRead = 0;
    int errors = 0;
    int cycles = 0;

    sdmacDatapath dut (.*);

    // Every req and ack of the outer ports and the internal links, plus the output enable
    assign linkBits = {cpuWrAck, cpuRdAck, scsiOutReq, scsiInAck, dataOutEnable,
                       dut.wrFifoReq, dut.wrFifoAck, dut.fifoSerReq, dut.fifoSerAck,
                       dut.packFifoReq, dut.packFifoAck, dut.fifoRdReq, dut.fifoRdAck};

    task automatic flagError(input string msg);
        errors = errors + 1;
        $display("%s", msg);
    endtask

    resetQuiet: assert property (@(posedge CLK) $past(reset) |-> (linkBits == '0))
        else flagError($sformatf("error linkBits expected %h actual %h",
                                 13'h0, $sampled(linkBits)));

    halfOrder: assert property (@(posedge CLK) disable iff (reset)
        (halfStrobe && halfExpected) |-> (gotHalf == expHalf))
        else flagError($sformatf("error scsiOutData expected %h actual %h",
                                 $sampled(expHalf), $sampled(gotHalf)));

    noExtraHalf: assert property (@(posedge CLK) disable iff (reset)
        halfStrobe |-> halfExpected)
        else flagError("SCSI sent a half that no CPU write asked for");

    wordOrder: assert property (@(posedge CLK) disable iff (reset)
        (wordStrobe && wordExpected) |-> (gotWord == expWord))
        else flagError($sformatf("error cpuRdWord expected %h actual %h",
                                 $sampled(expWord), $sampled(gotWord)));

    noExtraWord: assert property (@(posedge CLK) disable iff (reset)
        wordStrobe |-> wordExpected)
        else flagError("CPU read a word that no SCSI transfer produced");

    outEnable: assert property (@(posedge CLK) disable iff (reset)
        dataOutEnable == (cpuRdReq && (dmaDir == sdmacCtrlPkg::toCpu)))
        else flagError($sformatf("error dataOutEnable expected %h actual %h",
                                 $sampled(cpuRdReq && (dmaDir == sdmacCtrlPkg::toCpu)),
                                 $sampled(dataOutEnable)));

    ackNeedsReq: assert property (@(posedge CLK) disable iff (reset)
        !(($rose(cpuWrAck) && !cpuWrReq) || ($rose(cpuRdAck) && !cpuRdReq) ||
          ($rose(scsiInAck) && !scsiInReq)))
        else flagError("an ack rose while its request was low");

    scsiReqWaits: assert property (@(posedge CLK) disable iff (reset)
        $rose(scsiOutReq) |-> !scsiOutAck)
        else flagError("scsiOutReq rose while scsiOutAck was still high");

    writeRefused: assert property (@(posedge CLK) disable iff (reset)
        ($past(dmaDir) == sdmacCtrlPkg::toCpu) |-> !$rose(cpuWrAck))
        else flagError("a CPU write was acked while the direction was toCpu");

    // With SCSI stalled only the buffer's words may be acked
    // The serializer's word stays in the buffer until its last half is out
    bufferBound: assert property (@(posedge CLK) disable iff (reset)
        holdOff |-> (wrAcked <= sdmacCtrlPkg::fifoDepth))
        else flagError("more CPU writes were acked than the buffers can hold");

    // By then the buffer has to be full and the next write held back
    cpuStalled: assert property (@(posedge CLK) disable iff (reset)
        stallStrobe |-> (wrAcked == sdmacCtrlPkg::fifoDepth))
        else flagError("CPU writes were not held back at a full buffer while SCSI stalled");

    // One CPU write; the enabled halves are queued lower half first
    task automatic cpuWrite(input logic [1:0] lanes);
        sdmacDataPkg::outWordT w;
        w.data = $urandom;
        w.laneEnable = lanes;
        if (lanes[0]) expHalves.push_back(w.data[sdmacDataPkg::halfWidth-1:0]);
        if (lanes[1]) expHalves.push_back(w.data[sdmacDataPkg::wordWidth-1:
                                                 sdmacDataPkg::halfWidth]);
        cpuWrWord <= w;
        cpuWrReq <= 1'b1;
        do @(posedge CLK); while (!cpuWrAck);
        wrAcked = wrAcked + 1;
        writesDone = writesDone + 1;
        cpuWrReq <= 1'b0;
        do @(posedge CLK); while (cpuWrAck);
    endtask

    task automatic cpuRead();
        cpuRdReq <= 1'b1;
        do @(posedge CLK); while (!cpuRdAck);
        gotWord <= cpuRdWord;
        wordExpected <= (expWords.size() != 0);
        if (expWords.size() != 0) expWord <= expWords.pop_front();
        wordStrobe <= 1'b1;
        wordsRead = wordsRead + 1;
        cpuRdReq <= 1'b0;
        @(posedge CLK);
        wordStrobe <= 1'b0;
        while (cpuRdAck) @(posedge CLK);
    endtask

    task automatic scsiSend(input sdmacDataPkg::halfT h);
        scsiInData <= h;
        scsiInReq <= 1'b1;
        do @(posedge CLK); while (!scsiInAck);
        scsiInReq <= 1'b0;
        do @(posedge CLK); while (scsiInAck);
    endtask

    // SCSI target on the output port; holdOff keeps the ack away to fill the buffers
    // The ack also lingers after the request falls, so an early next request shows up
    task automatic serveScsiOut();
        forever begin
            @(posedge CLK);
            if (scsiOutReq && !scsiOutAck && !holdOff) begin
                repeat ($urandom_range(3, 0)) @(posedge CLK);
                gotHalf <= scsiOutData;
                halfExpected <= (expHalves.size() != 0);
                if (expHalves.size() != 0) expHalf <= expHalves.pop_front();
                halfStrobe <= 1'b1;
                halvesSeen = halvesSeen + 1;
                scsiOutAck <= 1'b1;
                @(posedge CLK);
                halfStrobe <= 1'b0;
                do @(posedge CLK); while (scsiOutReq);
                repeat ($urandom_range(3, 1)) @(posedge CLK);
                scsiOutAck <= 1'b0;
            end
        end
    endtask

    // Waits until every queued half has gone out and the last SCSI handshake has closed
    task automatic drainOut();
        while (expHalves.size() != 0) @(posedge CLK);
        do @(posedge CLK); while (scsiOutReq || scsiOutAck);
        repeat (4) @(posedge CLK);
    endtask

    // Sends random halves while the CPU reads; an odd count ends in a flushed lone half
    task automatic packRun(input int halves);
        sdmacDataPkg::halfT   h[$];
        sdmacDataPkg::inWordT w;
        for (int i = 0; i < halves; i++) h.push_back(sdmacDataPkg::halfT'($urandom));
        for (int i = 0; i + 1 < halves; i += 2) begin
            w.data = {h[i+1], h[i]};
            w.halfValid = 2'b11;
            expWords.push_back(w);
        end
        if (halves % 2 == 1) begin
            w.data = {{sdmacDataPkg::halfWidth{1'b0}}, h[halves-1]};
            w.halfValid = 2'b01;
            expWords.push_back(w);
        end
        fork
            begin
                foreach (h[i]) scsiSend(h[i]);
                scsiEnd <= 1'b1;
            end
            repeat ((halves + 1) / 2) cpuRead();
        join
        scsiEnd <= 1'b0;
        @(posedge CLK);
    endtask

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("timeout after %0d cycles, errors %0d", cycles, errors);
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h1324163e));
        reset <= 1'b1;
        dmaDir <= sdmacCtrlPkg::toScsi;
        cpuWrReq <= 1'b0;
        cpuWrWord <= '0;
        cpuRdReq <= 1'b0;
        scsiOutAck <= 1'b0;
        scsiInReq <= 1'b0;
        scsiInData <= '0;
        scsiEnd <= 1'b0;
        holdOff <= 1'b0;
        stallStrobe <= 1'b0;
        halfStrobe <= 1'b0;
        halfExpected <= 1'b0;
        gotHalf <= '0;
        expHalf <= '0;
        wordStrobe <= 1'b0;
        wordExpected <= 1'b0;
        gotWord <= '0;
        expWord <= '0;
        fork
            serveScsiOut();
        join_none
        repeat (10) @(posedge CLK);
        reset <= 1'b0;
        @(posedge CLK);
        // Full words go out lower half first in write order
        repeat (runWords) cpuWrite(2'b11);
        drainOut();
        // Random lanes, with the empty, lower-only and upper-only words forced in
        for (int i = 0; i < runWords; i++) begin
            cpuWrite((i == 2) ? 2'b00 : (i == 3) ? 2'b01 : (i == 4) ? 2'b10 : 2'($urandom));
        end
        drainOut();
        // SCSI stalls until the buffers are full and the CPU write stalls as well
        wrAcked = 0;
        holdOff <= 1'b1;
        fork
            repeat (backWords) cpuWrite(2'b11);
            begin
                repeat (80) @(posedge CLK);
                stallStrobe <= 1'b1;
                @(posedge CLK);
                stallStrobe <= 1'b0;
                holdOff <= 1'b0;
            end
        join
        drainOut();
        // A read request in toScsi must leave the data drivers off
        cpuRdReq <= 1'b1;
        repeat (3) @(posedge CLK);
        cpuRdReq <= 1'b0;
        dmaDir <= sdmacCtrlPkg::toCpu;
        @(posedge CLK);
        // A write held up in toCpu is never acked
        cpuWrReq <= 1'b1;
        repeat (20) @(posedge CLK);
        cpuWrReq <= 1'b0;
        @(posedge CLK);
        packRun(2 * runWords);
        packRun(2 * runWords - 1);
        repeat (4) @(posedge CLK);
        $display("writes %0d halves %0d words %0d errors %0d",
                 writesDone, halvesSeen, wordsRead, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
